// File: verilog/lc3b_types.sv
package lc3b_types;

    // width of a processor word and of an address.
    localparam int WORD_BITS = 16;

    typedef logic [WORD_BITS-1:0] lc3b_word;

    // one enable per byte of a word, bit 0 for the low byte.
    typedef logic [1:0] lc3b_mem_wmask;

    // a word request from the processor to an L1 cache.
    // at most one of read and write is set, and the request is held until resp.
    typedef struct packed {
        logic          read;
        logic          write;
        lc3b_mem_wmask byte_enable;
        lc3b_word      address;
        lc3b_word      wdata;
    } cpu_req_t;

endpackage : lc3b_types

// File: verilog/cache_types.sv
package cache_types;

    import lc3b_types::*;

    // byte offset within a 16-byte line.
    localparam int OFFSET_BITS = 4;

    localparam int L1_INDEX_BITS = 3;
    localparam int L2_INDEX_BITS = 4;

    localparam int LINE_BITS      = 128;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

    typedef logic [LINE_BITS-1:0] lc3b_line;

    // a whole-line request between cache levels.
    // the address is line aligned, so its low offset bits are zero.
    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word address;
        lc3b_line wdata;
    } line_req_t;

    // miss handling states shared by both cache levels.
    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPARE,
        S_WRITEBACK,
        S_FILL
    } cache_state_t;

endpackage : cache_types

// File: verilog/cache_store.sv
`timescale 1ns/1ns

module cache_store
    import lc3b_types::*;
    import cache_types::*;
#(
    parameter int INDEX_BITS = L1_INDEX_BITS
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  lc3b_word i_address,
    input  logic     i_fill,
    input  lc3b_line i_fill_line,
    input  logic     i_mark_dirty,
    input  lc3b_line i_write_line,
    output logic     o_hit,
    output logic     o_dirty,
    output lc3b_line o_line,
    output lc3b_word o_victim_address
);

    localparam int SETS     = 1 << INDEX_BITS;
    localparam int TAG_BITS = WORD_BITS - INDEX_BITS - OFFSET_BITS;

    logic [TAG_BITS-1:0]   tag_array  [SETS];
    lc3b_line              data_array [SETS];
    logic [SETS-1:0]       valid_bits;
    logic [SETS-1:0]       dirty_bits;

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;

    assign index = i_address[OFFSET_BITS +: INDEX_BITS];
    assign tag   = i_address[WORD_BITS-1 -: TAG_BITS];

    // a fill installs a clean line, and a write to a resident line makes it dirty.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (i_fill) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
        end else if (i_mark_dirty) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_array[index]  <= tag;
            data_array[index] <= i_fill_line;
        end else if (i_mark_dirty) begin
            data_array[index] <= i_write_line;
        end
    end

    assign o_hit   = valid_bits[index] && (tag_array[index] == tag);
    assign o_dirty = valid_bits[index] && dirty_bits[index];
    assign o_line  = data_array[index];

    // the evicted line lives at the stored tag in the same set.
    assign o_victim_address = {tag_array[index], index, {OFFSET_BITS{1'b0}}};

endmodule : cache_store

// File: verilog/l1_cache.sv
`timescale 1ns/1ns

module l1_cache
    import lc3b_types::*;
    import cache_types::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  cpu_req_t  i_req,
    input  logic      i_mem_resp,
    input  lc3b_line  i_mem_rdata,
    output logic      o_resp,
    output lc3b_word  o_rdata,
    output line_req_t o_mem_req
);

    cache_state_t state;
    cache_state_t state_next;

    logic                   hit;
    logic                   dirty;
    logic                   lookup;
    logic                   fill;
    logic                   mark_dirty;
    lc3b_line               line;
    lc3b_line               merged_line;
    lc3b_word               word_out;
    lc3b_word               victim_address;
    lc3b_word               line_address;
    logic [OFFSET_BITS-2:0] word_sel;

    cache_store #(
        .INDEX_BITS (L1_INDEX_BITS)
    ) store (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_address        (i_req.address),
        .i_fill           (fill),
        .i_fill_line      (i_mem_rdata),
        .i_mark_dirty     (mark_dirty),
        .i_write_line     (merged_line),
        .o_hit            (hit),
        .o_dirty          (dirty),
        .o_line           (line),
        .o_victim_address (victim_address)
    );

    assign word_sel     = i_req.address[OFFSET_BITS-1:1];
    assign line_address = {i_req.address[WORD_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // the requester still holds the old request while the response pulse is high,
    // so idle only takes a new one once the pulse has gone.
    // compare always looks up, and right after a fill it always hits.
    assign lookup = (state == S_IDLE && (i_req.read || i_req.write) && !o_resp) ||
                    (state == S_COMPARE);

    // select the addressed word and merge the enabled bytes of a write into the line.
    always_comb begin
        merged_line = line;
        word_out    = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (int'(word_sel) == w) begin
                word_out = line[w*WORD_BITS +: WORD_BITS];
                if (i_req.byte_enable[0]) begin
                    merged_line[w*WORD_BITS +: 8] = i_req.wdata[7:0];
                end
                if (i_req.byte_enable[1]) begin
                    merged_line[w*WORD_BITS+8 +: 8] = i_req.wdata[15:8];
                end
            end
        end
    end

    always_comb begin
        state_next = state;
        fill       = 1'b0;
        mark_dirty = 1'b0;
        o_mem_req  = '0;
        case (state)
            S_IDLE, S_COMPARE: begin
                if (lookup) begin
                    if (hit) begin
                        mark_dirty = i_req.write;
                        state_next = S_IDLE;
                    end else if (dirty) begin
                        state_next = S_WRITEBACK;
                    end else begin
                        state_next = S_FILL;
                    end
                end
            end
            S_WRITEBACK: begin
                o_mem_req.write   = 1'b1;
                o_mem_req.address = victim_address;
                o_mem_req.wdata   = line;
                if (i_mem_resp) begin
                    state_next = S_FILL;
                end
            end
            S_FILL: begin
                o_mem_req.read    = 1'b1;
                o_mem_req.address = line_address;
                if (i_mem_resp) begin
                    fill       = 1'b1;
                    state_next = S_COMPARE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= S_IDLE;
            o_resp <= 1'b0;
        end else begin
            state  <= state_next;
            o_resp <= lookup && hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && hit) begin
            o_rdata <= word_out;
        end
    end

    // the processor side never asks for a read and a write at once.
    a_req_single_op: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_req.read && i_req.write));

endmodule : l1_cache

// File: verilog/l2_cache.sv
`timescale 1ns/1ns

module l2_cache
    import lc3b_types::*;
    import cache_types::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  line_req_t i_req,
    input  logic      i_pmem_resp,
    input  lc3b_line  i_pmem_rdata,
    output logic      o_resp,
    output lc3b_line  o_rdata,
    output line_req_t o_pmem_req
);

    cache_state_t state;
    cache_state_t state_next;

    logic     hit;
    logic     dirty;
    logic     lookup;
    logic     fill;
    logic     mark_dirty;
    lc3b_line line;
    lc3b_word victim_address;

    cache_store #(
        .INDEX_BITS (L2_INDEX_BITS)
    ) store (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_address        (i_req.address),
        .i_fill           (fill),
        .i_fill_line      (i_pmem_rdata),
        .i_mark_dirty     (mark_dirty),
        .i_write_line     (i_req.wdata),
        .o_hit            (hit),
        .o_dirty          (dirty),
        .o_line           (line),
        .o_victim_address (victim_address)
    );

    // same acceptance rule as the L1, one lookup per held request.
    assign lookup = (state == S_IDLE && (i_req.read || i_req.write) && !o_resp) ||
                    (state == S_COMPARE);

    // a line write still allocates, then replaces the whole fetched line.
    always_comb begin
        state_next = state;
        fill       = 1'b0;
        mark_dirty = 1'b0;
        o_pmem_req = '0;
        case (state)
            S_IDLE, S_COMPARE: begin
                if (lookup) begin
                    if (hit) begin
                        mark_dirty = i_req.write;
                        state_next = S_IDLE;
                    end else if (dirty) begin
                        state_next = S_WRITEBACK;
                    end else begin
                        state_next = S_FILL;
                    end
                end
            end
            S_WRITEBACK: begin
                o_pmem_req.write   = 1'b1;
                o_pmem_req.address = victim_address;
                o_pmem_req.wdata   = line;
                if (i_pmem_resp) begin
                    state_next = S_FILL;
                end
            end
            S_FILL: begin
                o_pmem_req.read    = 1'b1;
                o_pmem_req.address = i_req.address;
                if (i_pmem_resp) begin
                    fill       = 1'b1;
                    state_next = S_COMPARE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= S_IDLE;
            o_resp <= 1'b0;
        end else begin
            state  <= state_next;
            o_resp <= lookup && hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && hit) begin
            o_rdata <= line;
        end
    end

    // the arbiter must keep the granted request in place through the response.
    a_resp_while_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_resp |-> (i_req.read || i_req.write));

endmodule : l2_cache

// File: verilog/arbiter.sv
`timescale 1ns/1ns

module arbiter
    import cache_types::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  line_req_t i_ireq,
    input  line_req_t i_dreq,
    input  logic      i_l2_resp,
    output logic      o_iresp,
    output logic      o_dresp,
    output line_req_t o_l2_req
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

    arb_state_t state;
    logic       owner_d;
    logic       d_pending;
    logic       i_pending;
    logic       sel_d;

    assign d_pending = i_dreq.read || i_dreq.write;
    assign i_pending = i_ireq.read || i_ireq.write;

    // while idle the data side wins, and once busy the recorded owner keeps the port.
    assign sel_d = (state == ARB_BUSY) ? owner_d : d_pending;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ARB_IDLE;
            owner_d <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if ((d_pending || i_pending) && !i_l2_resp) begin
                        state   <= ARB_BUSY;
                        owner_d <= d_pending;
                    end
                end
                ARB_BUSY: begin
                    if (i_l2_resp) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign o_l2_req = sel_d ? i_dreq : i_ireq;
    assign o_dresp  = i_l2_resp && sel_d;
    assign o_iresp  = i_l2_resp && !sel_d;

    a_resp_exclusive: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_iresp && o_dresp));

endmodule : arbiter

// File: verilog/mp3.sv
`timescale 1ns/1ns

module mp3
    import lc3b_types::*;
    import cache_types::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  cpu_req_t  i_ireq,
    input  cpu_req_t  i_dreq,
    input  logic      i_pmem_resp,
    input  lc3b_line  i_pmem_rdata,
    output logic      o_iresp,
    output lc3b_word  o_irdata,
    output logic      o_dresp,
    output lc3b_word  o_drdata,
    output line_req_t o_pmem_req
);

    line_req_t icache_mem_req;
    line_req_t dcache_mem_req;
    logic      icache_mem_resp;
    logic      dcache_mem_resp;
    line_req_t l2_req;
    logic      l2_resp;
    lc3b_line  l2_rdata;

    // both L1 caches see the L2 read data, and only the one given resp captures it.
    l1_cache i_cache (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_ireq),
        .i_mem_resp  (icache_mem_resp),
        .i_mem_rdata (l2_rdata),
        .o_resp      (o_iresp),
        .o_rdata     (o_irdata),
        .o_mem_req   (icache_mem_req)
    );

    l1_cache d_cache (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_dreq),
        .i_mem_resp  (dcache_mem_resp),
        .i_mem_rdata (l2_rdata),
        .o_resp      (o_dresp),
        .o_rdata     (o_drdata),
        .o_mem_req   (dcache_mem_req)
    );

    arbiter arbiter (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_ireq    (icache_mem_req),
        .i_dreq    (dcache_mem_req),
        .i_l2_resp (l2_resp),
        .o_iresp   (icache_mem_resp),
        .o_dresp   (dcache_mem_resp),
        .o_l2_req  (l2_req)
    );

    l2_cache l2_cache (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_req        (l2_req),
        .i_pmem_resp  (i_pmem_resp),
        .i_pmem_rdata (i_pmem_rdata),
        .o_resp       (l2_resp),
        .o_rdata      (l2_rdata),
        .o_pmem_req   (o_pmem_req)
    );

endmodule : mp3

// File: tb/mp3_checker.sv
`timescale 1ns/1ns

module mp3_checker
    import lc3b_types::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  cpu_req_t     i_ireq,
    input  cpu_req_t     i_dreq,
    input  logic         i_iresp,
    input  lc3b_word     i_irdata,
    input  logic         i_dresp,
    input  lc3b_word     i_drdata,
    input  logic [127:0] i_iname,
    input  logic [127:0] i_dname,
    output int           o_tests,
    output int           o_errors
);

    // shadow of memory as the processor sees it, keyed by word address.
    lc3b_word shadow [lc3b_word];
    int       test_count = 0;
    int       error_count = 0;

    assign o_tests  = test_count;
    assign o_errors = error_count;

    function automatic lc3b_word shadow_read(lc3b_word address);
        lc3b_word a;
        a = {address[WORD_BITS-1:1], 1'b0};
        if (shadow.exists(a)) begin
            return shadow[a];
        end else begin
            return a ^ 16'hA5A5;
        end
    endfunction

    task automatic check_response(input logic [127:0] name, input cpu_req_t req,
                                  input lc3b_word rdata);
        lc3b_word expected;
        lc3b_word merged;
        expected = shadow_read(req.address);
        test_count++;
        if (!req.read && !req.write) begin
            error_count++;
            $display("test %0s got a response while no request was held", name);
        end else if (req.write) begin
            merged = expected;
            if (req.byte_enable[0]) begin
                merged[7:0] = req.wdata[7:0];
            end
            if (req.byte_enable[1]) begin
                merged[15:8] = req.wdata[15:8];
            end
            shadow[{req.address[WORD_BITS-1:1], 1'b0}] = merged;
            $display("%0s: ok, wrote %h at %h with enables %b",
                     name, req.wdata, req.address, req.byte_enable);
        end else if (rdata !== expected) begin
            error_count++;
            $display("[ERROR] %0s: expected %h, actual %h", name, expected, rdata);
        end else begin
            $display("%0s: ok, read %h at %h", name, rdata, req.address);
        end
    endtask

    // the request is still held in the cycle of its resp pulse.
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (i_iresp) begin
                check_response(i_iname, i_ireq, i_irdata);
            end
            if (i_dresp) begin
                check_response(i_dname, i_dreq, i_drdata);
            end
        end
    end

endmodule : mp3_checker

// File: tb/tb_mp3.sv
`timescale 1ns/1ns

module tb_mp3
    import lc3b_types::*;
    import cache_types::*;
();

    localparam int RESP_TIMEOUT = 400;
    localparam int RANDOM_TESTS = 20;

    // one row of the stimulus table.
    // with_next launches the following row in the same cycle on the other port.
    typedef struct packed {
        logic [127:0]  name;
        logic          port_d;
        logic          with_next;
        logic          write;
        lc3b_mem_wmask byte_enable;
        lc3b_word      address;
        lc3b_word      wdata;
    } test_entry_t;

    logic         clk = 1'b0;
    logic         rst_n;
    cpu_req_t     ireq;
    cpu_req_t     dreq;
    logic [127:0] iname;
    logic [127:0] dname;
    logic         iresp;
    logic         dresp;
    lc3b_word     irdata;
    lc3b_word     drdata;
    line_req_t    pmem_req;
    logic         pmem_resp = 1'b0;
    lc3b_line     pmem_rdata = '0;

    test_entry_t  tests [$];
    integer       seed = 87;
    logic         timed_out = 1'b0;
    int           checked;
    int           errors;
    int           k;

    // physical memory holds only written lines, the rest follows the initial rule.
    lc3b_line     pmem [lc3b_word];
    logic         mem_busy = 1'b0;
    int           mem_wait = 0;

    always #4 clk = ~clk;

    mp3 DUT (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_ireq       (ireq),
        .i_dreq       (dreq),
        .i_pmem_resp  (pmem_resp),
        .i_pmem_rdata (pmem_rdata),
        .o_iresp      (iresp),
        .o_irdata     (irdata),
        .o_dresp      (dresp),
        .o_drdata     (drdata),
        .o_pmem_req   (pmem_req)
    );

    mp3_checker result_check (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .i_ireq   (ireq),
        .i_dreq   (dreq),
        .i_iresp  (iresp),
        .i_irdata (irdata),
        .i_dresp  (dresp),
        .i_drdata (drdata),
        .i_iname  (iname),
        .i_dname  (dname),
        .o_tests  (checked),
        .o_errors (errors)
    );

    function automatic lc3b_line pmem_line(lc3b_word address);
        lc3b_line line;
        lc3b_word base;
        lc3b_word a;
        base = {address[WORD_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        if (pmem.exists(base)) begin
            line = pmem[base];
        end else begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                a = base + lc3b_word'(2 * w);
                line[w*WORD_BITS +: WORD_BITS] = a ^ 16'hA5A5;
            end
        end
        return line;
    endfunction

    // a request is answered after 2 to 9 cycles with a one-cycle resp pulse.
    always @(negedge clk) begin
        if (!rst_n) begin
            pmem_resp <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait > 1) begin
                mem_wait <= mem_wait - 1;
            end else begin
                if (pmem_req.write) begin
                    pmem[{pmem_req.address[WORD_BITS-1:OFFSET_BITS], 4'b0}] = pmem_req.wdata;
                end
                pmem_rdata <= pmem_line(pmem_req.address);
                pmem_resp  <= 1'b1;
                mem_busy   <= 1'b0;
            end
        end else if (pmem_req.read || pmem_req.write) begin
            mem_busy <= 1'b1;
            mem_wait <= 2 + int'($unsigned($random(seed)) % 32'd8);
        end
    end

    function automatic void add_test(input logic [127:0] name, input logic port_d,
                                     input logic with_next, input logic write,
                                     input lc3b_mem_wmask be, input lc3b_word address,
                                     input lc3b_word wdata);
        test_entry_t e;
        e.name        = name;
        e.port_d      = port_d;
        e.with_next   = with_next;
        e.write       = write;
        e.byte_enable = be;
        e.address     = address;
        e.wdata       = wdata;
        tests.push_back(e);
    endfunction

    task automatic add_random_tests();
        logic [31:0]   rnd;
        logic [31:0]   data;
        logic [127:0]  name;
        lc3b_word      address;
        logic          port_d;
        logic          write;
        lc3b_mem_wmask be;
        for (int n = 0; n < RANDOM_TESTS; n++) begin
            rnd     = $random(seed);
            data    = $random(seed);
            port_d  = rnd[0];
            write   = rnd[0] && rnd[1];
            be      = (write && rnd[3:2] != 2'b00) ? rnd[3:2] : 2'b11;
            // the instruction cache never sees data writes, so fetches use the next 1 KB.
            address = port_d ? {6'b0, rnd[12:4], 1'b0} : {5'b0, 1'b1, rnd[12:4], 1'b0};
            name       = "random_00";
            name[15:8] = 8'(48 + n / 10);
            name[7:0]  = 8'(48 + n % 10);
            add_test(name, port_d, 1'b0, write, be, address, data[15:0]);
        end
    endtask

    task automatic build_table();
        add_test("cold_ifetch", 1'b0, 1'b0, 1'b0, 2'b11, 16'h0040, 16'h0000);
        add_test("cold_dread", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0042, 16'h0000);
        add_test("write_be01", 1'b1, 1'b0, 1'b1, 2'b01, 16'h0050, 16'h1234);
        add_test("read_be01", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0050, 16'h0000);
        add_test("write_be10", 1'b1, 1'b0, 1'b1, 2'b10, 16'h0052, 16'hABCD);
        add_test("read_be10", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0052, 16'h0000);
        add_test("write_be11", 1'b1, 1'b0, 1'b1, 2'b11, 16'h0054, 16'hBEEF);
        add_test("read_be11", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0054, 16'h0000);
        // 128 bytes away shares the L1 set, 256 bytes away shares the L2 set.
        add_test("l1_conflict", 1'b1, 1'b0, 1'b0, 2'b11, 16'h00D0, 16'h0000);
        add_test("l1_reread", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0050, 16'h0000);
        add_test("l2_conflict", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0150, 16'h0000);
        add_test("l2_reread", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0052, 16'h0000);
        add_test("pair_ifetch", 1'b0, 1'b1, 1'b0, 2'b11, 16'h0060, 16'h0000);
        add_test("pair_dread", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0070, 16'h0000);
        add_test("pair_ifetch_hit", 1'b0, 1'b1, 1'b0, 2'b11, 16'h0044, 16'h0000);
        add_test("pair_dread_miss", 1'b1, 1'b0, 1'b0, 2'b11, 16'h0080, 16'h0000);
        add_random_tests();
    endtask

    task automatic apply_tests(input int first, input int count);
        test_entry_t e;
        int          cycles;
        logic        i_wait;
        logic        d_wait;
        logic        i_drop;
        logic        d_drop;
        i_wait = 1'b0;
        d_wait = 1'b0;
        i_drop = 1'b0;
        d_drop = 1'b0;
        @(negedge clk);
        for (int n = 0; n < count; n++) begin
            e = tests[first + n];
            if (e.port_d) begin
                dreq   = '{read: !e.write, write: e.write, byte_enable: e.byte_enable,
                           address: e.address, wdata: e.wdata};
                dname  = e.name;
                d_wait = 1'b1;
            end else begin
                ireq   = '{read: !e.write, write: e.write, byte_enable: e.byte_enable,
                           address: e.address, wdata: e.wdata};
                iname  = e.name;
                i_wait = 1'b1;
            end
        end
        cycles = 0;
        while ((i_wait || d_wait || i_drop || d_drop) && cycles < RESP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // a request is dropped one edge after its resp pulse was seen.
            if (i_drop) begin
                ireq   = '0;
                i_drop = 1'b0;
            end
            if (d_drop) begin
                dreq   = '0;
                d_drop = 1'b0;
            end
            if (i_wait && iresp) begin
                i_wait = 1'b0;
                i_drop = 1'b1;
            end
            if (d_wait && dresp) begin
                d_wait = 1'b0;
                d_drop = 1'b1;
            end
        end
        if (i_wait || d_wait) begin
            timed_out = 1'b1;
            $display("timeout: test %0s got no response within %0d cycles",
                     tests[first].name, RESP_TIMEOUT);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        ireq  = '0;
        dreq  = '0;
        iname = '0;
        dname = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        k = 0;
        while (k < tests.size() && !timed_out) begin
            if (tests[k].with_next) begin
                apply_tests(k, 2);
                k = k + 2;
            end else begin
                apply_tests(k, 1);
                k = k + 1;
            end
        end
        repeat (2) @(negedge clk);
        if (!timed_out && checked != tests.size()) begin
            $display("only %0d of %0d tests reported a result", checked, tests.size());
        end
        $display("tests: %0d, errors: %0d, timeouts: %0d", checked, errors, timed_out);
        if (timed_out || errors != 0 || checked != tests.size()) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule : tb_mp3

// File: vlog.f
verilog/lc3b_types.sv
verilog/cache_types.sv
verilog/cache_store.sv
verilog/l1_cache.sv
verilog/l2_cache.sv
verilog/arbiter.sv
verilog/mp3.sv
tb/mp3_checker.sv
tb/tb_mp3.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and search the log for the fail message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_mp3 \
    --Mdir obj_dir -o tb_mp3_sim > build.log 2>&1 \
    && ./obj_dir/tb_mp3_sim > sim.log 2>&1 \
    && ! grep -q "SIMULATION FAILED" sim.log \
    && echo "run passed, see sim.log" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }
